// ==== Bender.yml ====
package:
  name: flow_entry_host

sources:
  - files:
      - hw/flow_reg_pkg.sv
      - hw/reg_bus_if.sv
      - hw/flow_cmd_if.sv
      - hw/axil_reg_slave.sv
      - hw/flow_reg_decoder.sv
      - hw/flow_entry_buf.sv
      - hw/flow_table_access.sv
      - hw/flow_entry_host.sv

  - target: test
    include_dirs:
      - test
    files:
      - test/flow_entry_host_tb.sv

// ==== hw/axil_reg_slave.sv ====
`timescale 1ns/100ps
`default_nettype none

module axil_reg_slave import flow_reg_pkg::*; (
   input  logic                  aclk,
   input  logic                  aresetn,
   input  logic [axi_addr_w-1:0] awaddr,
   input  logic                  awvalid,
   output logic                  awready,
   input  reg_data_t             wdata,
   input  logic                  wvalid,
   output logic                  wready,
   output axi_resp_t             bresp,
   output logic                  bvalid,
   input  logic                  bready,
   input  logic [axi_addr_w-1:0] araddr,
   input  logic                  arvalid,
   output logic                  arready,
   output reg_data_t             rdata,
   output axi_resp_t             rresp,
   output logic                  rvalid,
   input  logic                  rready,
   reg_bus_if.slave              bus
);

   logic [$bits(aw_idle)-1:0] wr_state;
   logic [$bits(ar_idle)-1:0] rd_state;

   // Handshakes follow straight from the state
   assign awready = (wr_state == aw_idle);
   assign wready  = (wr_state == aw_data);
   assign bvalid  = (wr_state == aw_resp);
   assign arready = (rd_state == ar_idle);
   assign rvalid  = (rd_state == ar_resp);
   assign rresp   = resp_okay;

   // Register effect lands on the edge that takes wdata
   assign bus.wr_en   = wready && wvalid;
   assign bus.wr_data = wdata;

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         wr_state <= aw_idle;
      end else begin
         case (wr_state)
            aw_idle: begin
               if (awvalid) begin
                  wr_state <= aw_data;
               end
            end
            aw_data: begin
               if (wvalid) begin
                  wr_state <= aw_resp;
               end
            end
            aw_resp: begin
               if (bready) begin
                  wr_state <= aw_idle;
               end
            end
            default: wr_state <= aw_idle;
         endcase
      end
   end

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         rd_state <= ar_idle;
      end else begin
         case (rd_state)
            ar_idle: begin
               if (arvalid) begin
                  rd_state <= ar_wait;
               end
            end
            ar_wait: rd_state <= ar_resp;
            ar_resp: begin
               if (rready) begin
                  rd_state <= ar_idle;
               end
            end
            default: rd_state <= ar_idle;
         endcase
      end
   end

   // Address, response and read data holding registers
   always_ff @(posedge aclk) begin
      if (awready && awvalid) begin
         bus.wr_addr <= awaddr[reg_addr_w-1:0];
      end
      if (bus.wr_en) begin
         bresp <= bus.wr_ok ? resp_okay : resp_slverr;
      end
      if (arready && arvalid) begin
         bus.rd_addr <= araddr[reg_addr_w-1:0];
      end
      // Sampled once so the word stays put under rready back-pressure
      if (rd_state == ar_wait) begin
         rdata <= bus.rd_data;
      end
   end

   // Neither response channel may leave reset active
   assert property (@(posedge aclk) !aresetn |=> !bvalid && !rvalid);

endmodule

`default_nettype wire

// ==== hw/flow_cmd_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Access orders towards the sequencer and its completion strobes
interface flow_cmd_if;

   logic wr_order;
   logic mod_wr_order;
   logic rd_order;
   logic busy;
   logic entry_clear;
   logic stats_capture;

   modport decoder (output wr_order, mod_wr_order, rd_order, input busy);

   modport access (
      input  wr_order, mod_wr_order, rd_order,
      output busy, entry_clear, stats_capture
   );

   modport buffer (input entry_clear, stats_capture);

endinterface

`default_nettype wire

// ==== hw/flow_entry_buf.sv ====
`timescale 1ns/100ps
`default_nettype none

module flow_entry_buf import flow_reg_pkg::*; (
   input  logic                         aclk,
   input  logic                         aresetn,
   input  logic                         entry_we,
   input  logic [entry_idx_w-1:0]       entry_index,
   input  reg_data_t                    wr_data,
   flow_cmd_if.buffer                   cmd,
   input  logic [stats_w-1:0]           flow_entry_stats_in,
   output reg_data_t [stats_words-1:0]  entry_stats_rd,
   output logic [match_w-1:0]           flow_entry_match,
   output logic [match_w-1:0]           flow_entry_mask,
   output logic [action_w-1:0]          flow_entry_action,
   output logic [stats_w-1:0]           flow_entry_stats
);

   // Word 0 sits in the low bits
   reg_data_t [entry_words-1:0] entry_q;

   // A finished write leaves an empty buffer for the next entry
   always_ff @(posedge aclk) begin
      if (!aresetn || cmd.entry_clear) begin
         entry_q <= '0;
      end else if (entry_we) begin
         entry_q[entry_index] <= wr_data;
      end
   end

   // Stats as returned by the table on a read
   always_ff @(posedge aclk) begin
      if (cmd.stats_capture) begin
         entry_stats_rd <= flow_entry_stats_in;
      end
   end

   // Field views of the buffer
   assign flow_entry_match  = entry_q[mask_word-1:0];
   assign flow_entry_mask   = entry_q[action_word-1:mask_word];
   assign flow_entry_action = entry_q[stats_word-1:action_word];
   assign flow_entry_stats  = entry_q[entry_words-1:stats_word];

endmodule

`default_nettype wire

// ==== hw/flow_entry_host.sv ====
`timescale 1ns/100ps
`default_nettype none

module flow_entry_host import flow_reg_pkg::*; (
   input  logic                  aclk,
   input  logic                  aresetn,
   input  logic [axi_addr_w-1:0] awaddr,
   input  logic                  awvalid,
   output logic                  awready,
   input  reg_data_t             wdata,
   input  logic                  wvalid,
   output logic                  wready,
   output axi_resp_t             bresp,
   output logic                  bvalid,
   input  logic                  bready,
   input  logic [axi_addr_w-1:0] araddr,
   input  logic                  arvalid,
   output logic                  arready,
   output reg_data_t             rdata,
   output axi_resp_t             rresp,
   output logic                  rvalid,
   input  logic                  rready,
   output logic [tbl_addr_w-1:0] flow_entry_addr,
   output logic [match_w-1:0]    flow_entry_match,
   output logic [match_w-1:0]    flow_entry_mask,
   output logic [action_w-1:0]   flow_entry_action,
   output logic [stats_w-1:0]    flow_entry_stats,
   input  logic [stats_w-1:0]    flow_entry_stats_in,
   output logic                  flow_entry_wr,
   output logic                  flow_entry_stats_en,
   output logic                  flow_entry_req,
   input  logic                  flow_entry_ack,
   input  logic                  flow_entry_done,
   input  reg_data_t             exact_hit,
   input  reg_data_t             exact_miss,
   input  reg_data_t             wildcard_hit,
   input  reg_data_t             wildcard_miss
);

   logic                         entry_we;
   logic [entry_idx_w-1:0]       entry_index;
   reg_data_t [stats_words-1:0]  entry_stats_rd;

   reg_bus_if  reg_bus ();
   flow_cmd_if cmd_bus ();

   axil_reg_slave i_slave (
      .aclk    (aclk),
      .aresetn (aresetn),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rresp   (rresp),
      .rvalid  (rvalid),
      .rready  (rready),
      .bus     (reg_bus.slave)
   );

   flow_reg_decoder i_decoder (
      .aclk            (aclk),
      .aresetn         (aresetn),
      .bus             (reg_bus.decoder),
      .cmd             (cmd_bus.decoder),
      .flow_entry_addr (flow_entry_addr),
      .exact_hit       (exact_hit),
      .exact_miss      (exact_miss),
      .wildcard_hit    (wildcard_hit),
      .wildcard_miss   (wildcard_miss),
      .entry_we        (entry_we),
      .entry_index     (entry_index),
      .entry_stats_rd  (entry_stats_rd)
   );

   // Entry words come straight off the write data path
   flow_entry_buf i_buf (
      .aclk                (aclk),
      .aresetn             (aresetn),
      .entry_we            (entry_we),
      .entry_index         (entry_index),
      .wr_data             (reg_bus.wr_data),
      .cmd                 (cmd_bus.buffer),
      .flow_entry_stats_in (flow_entry_stats_in),
      .entry_stats_rd      (entry_stats_rd),
      .flow_entry_match    (flow_entry_match),
      .flow_entry_mask     (flow_entry_mask),
      .flow_entry_action   (flow_entry_action),
      .flow_entry_stats    (flow_entry_stats)
   );

   flow_table_access i_access (
      .aclk                (aclk),
      .aresetn             (aresetn),
      .cmd                 (cmd_bus.access),
      .flow_entry_req      (flow_entry_req),
      .flow_entry_wr       (flow_entry_wr),
      .flow_entry_stats_en (flow_entry_stats_en),
      .flow_entry_ack      (flow_entry_ack),
      .flow_entry_done     (flow_entry_done)
   );

endmodule

`default_nettype wire

// ==== hw/flow_reg_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module flow_reg_decoder import flow_reg_pkg::*; (
   input  logic                         aclk,
   input  logic                         aresetn,
   reg_bus_if.decoder                   bus,
   flow_cmd_if.decoder                  cmd,
   output logic [tbl_addr_w-1:0]        flow_entry_addr,
   input  reg_data_t                    exact_hit,
   input  reg_data_t                    exact_miss,
   input  reg_data_t                    wildcard_hit,
   input  reg_data_t                    wildcard_miss,
   output logic                         entry_we,
   output logic [entry_idx_w-1:0]       entry_index,
   input  reg_data_t [stats_words-1:0]  entry_stats_rd
);

   logic      order_ok;
   reg_addr_t stats_offset;

   // Everything below the end of the entry area answers okay
   assign bus.wr_ok = (bus.wr_addr < entry_end_reg);

   // Orders arriving during an access are dropped
   assign order_ok         = bus.wr_en && !cmd.busy;
   assign cmd.wr_order     = order_ok && (bus.wr_addr == write_order_reg);
   assign cmd.mod_wr_order = order_ok && (bus.wr_addr == mod_write_order_reg);
   assign cmd.rd_order     = order_ok && (bus.wr_addr == read_order_reg);

   assign entry_we    = bus.wr_en && bus.wr_ok && (bus.wr_addr >= entry_base_reg);
   assign entry_index = entry_idx_w'(bus.wr_addr - entry_base_reg);

   // Table base address
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         flow_entry_addr <= '0;
      end else if (bus.wr_en && (bus.wr_addr == base_addr_reg)) begin
         flow_entry_addr <= bus.wr_data[tbl_addr_w-1:0];
      end
   end

   assign stats_offset = bus.rd_addr - stats_base_reg;

   // Read multiplexer
   always_comb begin
      case (bus.rd_addr) inside
         base_addr_reg:     bus.rd_data = reg_data_t'(flow_entry_addr);
         acc_rdy_reg:       bus.rd_data = reg_data_t'(!cmd.busy);
         exact_hit_reg:     bus.rd_data = exact_hit;
         exact_miss_reg:    bus.rd_data = exact_miss;
         wildcard_hit_reg:  bus.rd_data = wildcard_hit;
         wildcard_miss_reg: bus.rd_data = wildcard_miss;
         // Only stats come back from the table
         [stats_base_reg : entry_end_reg - 1'b1]: begin
            bus.rd_data = entry_stats_rd[stats_offset];
         end
         [entry_base_reg : stats_base_reg - 1'b1]: begin
            bus.rd_data = '0;
         end
         default: bus.rd_data = unmapped_rdata;
      endcase
   end

   // A single write starts at most one access
   assert property (@(posedge aclk) disable iff (!aresetn)
      $onehot0({cmd.wr_order, cmd.mod_wr_order, cmd.rd_order}));

endmodule

`default_nettype wire

// ==== hw/flow_reg_pkg.sv ====
`default_nettype none

package flow_reg_pkg;

   // Bus and table widths
   localparam int axi_addr_w = 32;
   localparam int data_w     = 32;
   localparam int reg_addr_w = 8;
   localparam int tbl_addr_w = 16;

   // Flow entry fields in bits
   localparam int match_w  = 256;
   localparam int action_w = 320;
   localparam int stats_w  = 64;

   // Same fields in register words
   localparam int match_words  = match_w / data_w;
   localparam int action_words = action_w / data_w;
   localparam int stats_words  = stats_w / data_w;
   localparam int entry_words  = 2 * match_words + action_words + stats_words;
   localparam int entry_idx_w  = $clog2(entry_words);

   // Word offsets inside the entry buffer
   localparam int mask_word   = match_words;
   localparam int action_word = 2 * match_words;
   localparam int stats_word  = action_word + action_words;

   typedef logic [reg_addr_w-1:0] reg_addr_t;
   typedef logic [data_w-1:0]     reg_data_t;
   typedef logic [1:0]            axi_resp_t;

   // Register map
   localparam reg_addr_t base_addr_reg       = 8'h00;
   localparam reg_addr_t write_order_reg     = 8'h01;
   localparam reg_addr_t mod_write_order_reg = 8'h02;
   localparam reg_addr_t read_order_reg      = 8'h03;
   localparam reg_addr_t acc_rdy_reg         = 8'h04;
   localparam reg_addr_t exact_hit_reg       = 8'h05;
   localparam reg_addr_t exact_miss_reg      = 8'h06;
   localparam reg_addr_t wildcard_hit_reg    = 8'h07;
   localparam reg_addr_t wildcard_miss_reg   = 8'h08;

   // Entry area and the first address past the mapped space
   localparam reg_addr_t entry_base_reg = 8'h10;
   localparam reg_addr_t stats_base_reg = entry_base_reg + reg_addr_t'(stats_word);
   localparam reg_addr_t entry_end_reg  = entry_base_reg + reg_addr_t'(entry_words);

   localparam reg_data_t unmapped_rdata = 32'hDEAD_BEEF;

   localparam axi_resp_t resp_okay   = 2'b00;
   localparam axi_resp_t resp_slverr = 2'b10;

   // AXI-lite write channel states, one-hot
   localparam logic [2:0] aw_idle = 3'b001;
   localparam logic [2:0] aw_data = 3'b010;
   localparam logic [2:0] aw_resp = 3'b100;

   // AXI-lite read channel states, one-hot
   localparam logic [2:0] ar_idle = 3'b001;
   localparam logic [2:0] ar_wait = 3'b010;
   localparam logic [2:0] ar_resp = 3'b100;

   // Table access sequencer states, one-hot
   localparam logic [4:0] acc_idle      = 5'b00001;
   localparam logic [4:0] acc_wr_done   = 5'b00010;
   localparam logic [4:0] acc_rd_done   = 5'b00100;
   localparam logic [4:0] acc_wr_cancel = 5'b01000;
   localparam logic [4:0] acc_rd_cancel = 5'b10000;

endpackage

`default_nettype wire

// ==== hw/flow_table_access.sv ====
`timescale 1ns/100ps
`default_nettype none

module flow_table_access import flow_reg_pkg::*; (
   input  logic        aclk,
   input  logic        aresetn,
   flow_cmd_if.access  cmd,
   output logic        flow_entry_req,
   output logic        flow_entry_wr,
   output logic        flow_entry_stats_en,
   input  logic        flow_entry_ack,
   input  logic        flow_entry_done
);

   logic [$bits(acc_idle)-1:0] state;
   logic                       any_order;

   assign any_order = cmd.wr_order || cmd.mod_wr_order || cmd.rd_order;
   assign cmd.busy  = (state != acc_idle);

   // Stats are valid while the table holds done
   assign cmd.stats_capture = (state == acc_rd_done) && flow_entry_done;
   assign cmd.entry_clear   = (state == acc_wr_cancel) && !flow_entry_done;

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         state <= acc_idle;
      end else begin
         case (state)
            acc_idle: begin
               if (cmd.wr_order || cmd.mod_wr_order) begin
                  state <= acc_wr_done;
               end else if (cmd.rd_order) begin
                  state <= acc_rd_done;
               end
            end
            acc_wr_done: begin
               if (flow_entry_done) begin
                  state <= acc_wr_cancel;
               end
            end
            acc_rd_done: begin
               if (flow_entry_done) begin
                  state <= acc_rd_cancel;
               end
            end
            // Table drops done once it sees the request gone
            acc_wr_cancel, acc_rd_cancel: begin
               if (!flow_entry_done) begin
                  state <= acc_idle;
               end
            end
            default: state <= acc_idle;
         endcase
      end
   end

   // Request with its access type, both set by the order
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         flow_entry_req      <= 1'b0;
         flow_entry_wr       <= 1'b0;
         flow_entry_stats_en <= 1'b0;
      end else if ((state == acc_idle) && any_order) begin
         flow_entry_req      <= 1'b1;
         flow_entry_wr       <= !cmd.rd_order;
         // modify write keeps the stats in the table
         flow_entry_stats_en <= !cmd.mod_wr_order;
      end else if (flow_entry_ack || flow_entry_done) begin
         flow_entry_req <= 1'b0;
      end
   end

   // A request to the table only exists inside an access
   assert property (@(posedge aclk) disable iff (!aresetn) flow_entry_req |-> cmd.busy);

endmodule

`default_nettype wire

// ==== hw/reg_bus_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Register access path between the AXI-lite slave and the decoder
interface reg_bus_if import flow_reg_pkg::*; ();

   logic      wr_en;
   reg_addr_t wr_addr;
   reg_data_t wr_data;
   logic      wr_ok;
   reg_addr_t rd_addr;
   reg_data_t rd_data;

   modport slave (
      output wr_en, wr_addr, wr_data, rd_addr,
      input  wr_ok, rd_data
   );

   modport decoder (
      input  wr_en, wr_addr, wr_data, rd_addr,
      output wr_ok, rd_data
   );

endinterface

`default_nettype wire

// ==== project.f ====
+incdir+test
hw/flow_reg_pkg.sv
hw/reg_bus_if.sv
hw/flow_cmd_if.sv
hw/axil_reg_slave.sv
hw/flow_reg_decoder.sv
hw/flow_entry_buf.sv
hw/flow_table_access.sv
hw/flow_entry_host.sv
test/flow_entry_host_tb.sv

// ==== test/flow_entry_host_tests.svh ====
`ifndef FLOW_ENTRY_HOST_TESTS_SVH
`define FLOW_ENTRY_HOST_TESTS_SVH

// Polls acc_rdy until the access is over
task automatic wait_ready();
   reg_data_t rd;
   axi_resp_t resp;
   int        lat;
   int        polls;
   rd    = '0;
   polls = 0;
   while (rd[0] !== 1'b1 && polls < max_polls) begin
      axil_read(acc_rdy_reg, rd, resp, lat);
      polls++;
   end
   if (rd[0] !== 1'b1) begin
      errors++;
      $display("Access still busy after %0d status reads at %0t", polls, $time);
   end
endtask

task automatic fill_entry();
   axi_resp_t resp;
   int        i;
   for (i = 0; i < entry_words; i++) begin
      entry_model[i] = random_word();
      axil_write(entry_base_reg + i, entry_model[i], 0, resp);
      check_resp("bresp", resp, resp_okay);
   end
endtask

task automatic test_reset_state();
   reg_data_t rd;
   axi_resp_t resp;
   int        lat;
   check_bit("bvalid", bvalid, 1'b0);
   check_bit("rvalid", rvalid, 1'b0);
   check_bit("wready", wready, 1'b0);
   check_bit("arready", arready, 1'b1);
   check_bit("flow_entry_req", flow_entry_req, 1'b0);
   check_bit("flow_entry_wr", flow_entry_wr, 1'b0);
   axil_read(acc_rdy_reg, rd, resp, lat);
   check_data("acc_rdy", rd, 32'h1);
endtask

task automatic test_base_addr();
   reg_data_t rd;
   axi_resp_t resp;
   int        lat;
   axil_write(base_addr_reg, 32'h0001_ABCD, 0, resp);
   check_resp("bresp", resp, resp_okay);
   check_data("flow_entry_addr", reg_data_t'(flow_entry_addr), 32'h0000_ABCD);
   axil_read(base_addr_reg, rd, resp, lat);
   check_data("base_addr", rd, 32'h0000_ABCD);
endtask

// Fields seen by the table must match the words written
task automatic run_write(input reg_addr_t order, input logic exp_stats_en);
   axi_resp_t resp;
   int        count0;
   fill_entry();
   count0 = req_count;
   axil_write(order, random_word(), 0, resp);
   check_resp("bresp", resp, resp_okay);
   wait_ready();
   check_data("table requests", reg_data_t'(req_count - count0), 32'd1);
   check_bit("flow_entry_wr", seen_wr, 1'b1);
   check_bit("flow_entry_stats_en", seen_stats_en, exp_stats_en);
   check_field("flow_entry_match", seen_match, pack_words(0, match_words));
   check_field("flow_entry_mask", seen_mask, pack_words(mask_word, match_words));
   check_field("flow_entry_action", seen_action, pack_words(action_word, action_words));
   check_field("flow_entry_stats", seen_stats, pack_words(stats_word, stats_words));
   // Buffer empty again once the write is over
   check_field("flow_entry_match", flow_entry_match, '0);
   check_field("flow_entry_mask", flow_entry_mask, '0);
   check_field("flow_entry_action", flow_entry_action, '0);
   check_field("flow_entry_stats", flow_entry_stats, '0);
endtask

task automatic test_full_write();
   run_write(write_order_reg, 1'b1);
endtask

task automatic test_modify_write();
   run_write(mod_write_order_reg, 1'b0);
endtask

task automatic test_stats_read();
   reg_data_t rd;
   axi_resp_t resp;
   int        lat;
   int        count0;
   table_stats[31:0]  = random_word();
   table_stats[63:32] = random_word();
   count0 = req_count;
   axil_write(read_order_reg, '0, 0, resp);
   check_resp("bresp", resp, resp_okay);
   wait_ready();
   check_data("table requests", reg_data_t'(req_count - count0), 32'd1);
   check_bit("flow_entry_wr", seen_wr, 1'b0);
   check_bit("flow_entry_stats_en", seen_stats_en, 1'b1);
   axil_read(stats_base_reg, rd, resp, lat);
   check_data("stats low", rd, table_stats[31:0]);
   axil_read(stats_base_reg + 1, rd, resp, lat);
   check_data("stats high", rd, table_stats[63:32]);
   // Match words are not read back, even when the buffer holds one
   axil_write(entry_base_reg, random_word() | 32'h1, 0, resp);
   check_resp("bresp", resp, resp_okay);
   axil_read(entry_base_reg, rd, resp, lat);
   check_data("match word 0", rd, '0);
endtask

task automatic test_status_regs();
   reg_data_t rd;
   axi_resp_t resp;
   int        lat;
   axil_read(exact_hit_reg, rd, resp, lat);
   check_data("exact_hit", rd, exact_hit);
   check_data("rvalid delay", reg_data_t'(lat), 32'd2);
   axil_read(exact_miss_reg, rd, resp, lat);
   check_data("exact_miss", rd, exact_miss);
   axil_read(wildcard_hit_reg, rd, resp, lat);
   check_data("wildcard_hit", rd, wildcard_hit);
   axil_read(wildcard_miss_reg, rd, resp, lat);
   check_data("wildcard_miss", rd, wildcard_miss);
   axil_read(32'h09, rd, resp, lat);
   check_data("unmapped read", rd, 32'hDEAD_BEEF);
   check_resp("rresp", resp, resp_okay);
endtask

task automatic test_error_paths();
   axi_resp_t resp;
   // Response held under back-pressure for five cycles
   axil_write(32'h40, random_word(), 5, resp);
   check_resp("bresp", resp, resp_slverr);
endtask

`endif

// ==== test/flow_entry_host_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module flow_entry_host_tb import flow_reg_pkg::*; ();

   // About 150 accesses of up to 12 cycles, doubled, plus slack
   localparam int max_accesses   = 150;
   localparam int access_cycles  = 12;
   localparam int timeout_cycles = 2 * max_accesses * access_cycles + 400;
   localparam int max_polls      = 20;

   logic                  aclk;
   logic                  aresetn;
   logic [axi_addr_w-1:0] awaddr;
   logic                  awvalid;
   logic                  awready;
   reg_data_t             wdata;
   logic                  wvalid;
   logic                  wready;
   axi_resp_t             bresp;
   logic                  bvalid;
   logic                  bready;
   logic [axi_addr_w-1:0] araddr;
   logic                  arvalid;
   logic                  arready;
   reg_data_t             rdata;
   axi_resp_t             rresp;
   logic                  rvalid;
   logic                  rready;
   logic [tbl_addr_w-1:0] flow_entry_addr;
   logic [match_w-1:0]    flow_entry_match;
   logic [match_w-1:0]    flow_entry_mask;
   logic [action_w-1:0]   flow_entry_action;
   logic [stats_w-1:0]    flow_entry_stats;
   logic [stats_w-1:0]    flow_entry_stats_in;
   logic                  flow_entry_wr;
   logic                  flow_entry_stats_en;
   logic                  flow_entry_req;
   logic                  flow_entry_ack;
   logic                  flow_entry_done;
   reg_data_t             exact_hit;
   reg_data_t             exact_miss;
   reg_data_t             wildcard_hit;
   reg_data_t             wildcard_miss;

   int          checks;
   int          errors;
   logic [31:0] lfsr_q;
   reg_data_t   entry_model [entry_words];

   // Table model state and what it saw with the last request
   logic [stats_w-1:0]  table_stats;
   logic                model_req;
   int                  req_count;
   logic                seen_wr;
   logic                seen_stats_en;
   logic [match_w-1:0]  seen_match;
   logic [match_w-1:0]  seen_mask;
   logic [action_w-1:0] seen_action;
   logic [stats_w-1:0]  seen_stats;

   flow_entry_host i_dut (.*);

   initial begin
      aclk = 1'b0;
      forever #5 aclk = ~aclk;
   end

   // Taps 32, 22, 2, 1
   function automatic logic lfsr_step();
      logic fb;
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      return fb;
   endfunction

   function automatic reg_data_t random_word();
      reg_data_t w;
      int        i;
      w = '0;
      for (i = 0; i < data_w; i++) begin
         w = {w[data_w-2:0], lfsr_step()};
      end
      return w;
   endfunction

   // Word 0 of a field ends up in its low bits
   function automatic logic [action_w-1:0] pack_words(input int first, input int count);
      logic [action_w-1:0] f;
      int                  i;
      f = '0;
      for (i = count - 1; i >= 0; i--) begin
         f = (f << data_w) | action_w'(entry_model[first + i]);
      end
      return f;
   endfunction

   task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_field(input string name, input logic [action_w-1:0] got,
                              input logic [action_w-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // Bready held low for hold cycles once the response is up
   task automatic axil_write(input logic [axi_addr_w-1:0] addr, input reg_data_t data,
                             input int hold, output axi_resp_t resp);
      awaddr  = addr;
      awvalid = 1'b1;
      @(negedge aclk);
      while (!awready) @(negedge aclk);
      @(posedge aclk);
      #1;
      awvalid = 1'b0;
      wdata   = data;
      wvalid  = 1'b1;
      @(negedge aclk);
      while (!wready) @(negedge aclk);
      @(posedge aclk);
      #1;
      wvalid = 1'b0;
      repeat (hold) begin
         @(posedge aclk);
         #1;
         check_bit("bvalid", bvalid, 1'b1);
         check_bit("awready", awready, 1'b0);
      end
      bready = 1'b1;
      @(negedge aclk);
      while (!bvalid) @(negedge aclk);
      resp = bresp;
      @(posedge aclk);
      #1 bready = 1'b0;
   endtask

   // Lat counts edges from the accepting one until rvalid is up
   task automatic axil_read(input logic [axi_addr_w-1:0] addr, output reg_data_t data,
                            output axi_resp_t resp, output int lat);
      araddr  = addr;
      arvalid = 1'b1;
      @(negedge aclk);
      while (!arready) @(negedge aclk);
      @(posedge aclk);
      lat = 1;
      #1;
      arvalid = 1'b0;
      rready  = 1'b1;
      @(negedge aclk);
      while (!rvalid) begin
         @(posedge aclk);
         lat++;
         @(negedge aclk);
      end
      data = rdata;
      resp = rresp;
      @(posedge aclk);
      #1 rready = 1'b0;
   endtask

   // Flow table model acks, raises done three cycles later and drops it once the request is gone
   initial begin : table_model
      flow_entry_ack      = 1'b0;
      flow_entry_done     = 1'b0;
      flow_entry_stats_in = '0;
      model_req           = 1'b0;
      req_count           = 0;
      forever begin
         @(posedge aclk);
         #1;
         if (aresetn && flow_entry_req) begin
            seen_wr        = flow_entry_wr;
            seen_stats_en  = flow_entry_stats_en;
            seen_match     = flow_entry_match;
            seen_mask      = flow_entry_mask;
            seen_action    = flow_entry_action;
            seen_stats     = flow_entry_stats;
            req_count++;
            model_req      = 1'b1;
            flow_entry_ack = 1'b1;
            @(posedge aclk);
            #1 flow_entry_ack = 1'b0;
            repeat (2) @(posedge aclk);
            #1;
            flow_entry_stats_in = table_stats;
            flow_entry_done     = 1'b1;
            while (flow_entry_req || model_req) begin
               @(posedge aclk);
               #1;
               // Done has been seen by the DUT at this edge
               model_req = 1'b0;
            end
            flow_entry_done = 1'b0;
         end
      end
   end

   `include "flow_entry_host_tests.svh"

   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < timeout_cycles) begin
         @(posedge aclk);
         cycles++;
      end
      $display("Timeout: tests still running after %0d cycles", cycles);
      $display("** FAIL **");
      $finish;
   end

   initial begin : main
      checks      = 0;
      errors      = 0;
      lfsr_q      = 32'h47e3;
      table_stats = '0;
      aresetn     = 1'b0;
      awaddr      = '0;
      awvalid     = 1'b0;
      wdata       = '0;
      wvalid      = 1'b0;
      bready      = 1'b0;
      araddr      = '0;
      arvalid     = 1'b0;
      rready      = 1'b0;
      exact_hit     = random_word();
      exact_miss    = random_word();
      wildcard_hit  = random_word();
      wildcard_miss = random_word();
      repeat (2) @(posedge aclk);
      #1 aresetn = 1'b1;
      test_reset_state();
      test_base_addr();
      test_full_write();
      test_modify_write();
      test_stats_read();
      test_status_regs();
      test_error_paths();
      $display("Checks: %0d  errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire
